// File: files.f
verilog/pdp8Pkg.sv
verilog/coreMemory.sv
verilog/instRegister.sv
verilog/majorSequencer.sv
verilog/operateUnit.sv
verilog/pdp8Core.sv
dv/pdp8Assertions.sv
dv/pdp8Tb.sv

// File: Makefile
# Verilator build and run of the PDP-8 testbench

VERILATOR ?= verilator
TOP ?= pdp8Tb
FLAGS ?= -Wno-fatal

OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP) -f files.f

# Pass only when the simulation prints the pass message
run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

lint:
	$(VERILATOR) --lint-only --timing -Wall $(FLAGS) --top-module $(TOP) -f files.f

clean:
	rm -rf $(OBJ_DIR)

// File: dv/pdp8Tb.sv
`timescale 1ns/1ps
`default_nettype none

module pdp8Tb
  import pdp8Pkg::*;
();

  localparam int clockPeriod = 8;
  localparam word startAddr = 12'o0200;
  // Upper bounds over all tests, 8 cycles covers the longest instruction
  localparam int totalInst = 240;
  localparam int setupCycles = 400;
  localparam int watchdogCycles = 2 * (8 * totalInst + setupCycles);

  logic clk;
  logic reset;
  logic run;
  logic halt;
  logic depositEn;
  word depositAddr;
  word depositData;
  logic pcLoad;
  word pc;
  word acc;
  logic link;
  word mq;
  opcode opcodeOut;
  logic halted;
  logic instDone;
  logic memWrEn;
  word memAddr;
  word memWrData;

  // Program image still to be deposited
  word imgAddr[$];
  word imgData[$];
  word nextAddr;

  // Reference machine state
  word modelMem [memDepth];
  word modelAc;
  logic modelLink;
  word modelMq;
  word modelPc;
  logic [2:0] modelOp;
  logic modelWrite;
  word modelWrAddr;
  word modelWrData;
  logic modelHlt;

  int errorCount;
  int checkCount;
  int testCount;
  int instCount;
  logic checkPending;
  logic haltSeen;
  logic expHalted;

  pdp8Core dut (
    .SYSCLK     (clk),
    .reset      (reset),
    .run        (run),
    .halt       (halt),
    .depositEn  (depositEn),
    .depositAddr(depositAddr),
    .depositData(depositData),
    .pcLoad     (pcLoad),
    .pc         (pc),
    .acc        (acc),
    .link       (link),
    .mq         (mq),
    .opcode     (opcodeOut),
    .halted     (halted),
    .instDone   (instDone),
    .memWrEn    (memWrEn),
    .memAddr    (memAddr),
    .memWrData  (memWrData)
  );

  bind pdp8Core pdp8Assertions assertionChecks (
    .SYSCLK  (SYSCLK),
    .reset   (reset),
    .halted  (halted),
    .instDone(instDone),
    .memWrEn (memWrEn)
  );

  initial begin
    clk = 1'b0;
    forever #(clockPeriod / 2) clk = ~clk;
  end

  task automatic checkValue(input string name, input word got, input word expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("[ERROR] %0t %s: got %o, expected %o", $time, name, got, expected);
    end
  endtask

  function automatic word randomWord();
    return word'($urandom);
  endfunction

  task automatic addWord(input word addr, input word data);
    imgAddr.push_back(addr);
    imgData.push_back(data);
  endtask

  // Next program word at the running address
  task automatic emit(input word data);
    addWord(nextAddr, data);
    nextAddr = nextAddr + 1'b1;
  endtask

  // Operate instructions on the model, PC already points past the word
  function automatic void operateModel(input word inst);
    logic [wordWidth:0] lac;
    logic cond;
    word oldMq;
    oldMq = modelMq;
    if (!inst[8]) begin
      if (inst[7]) modelAc = '0;
      if (inst[6]) modelLink = 1'b0;
      if (inst[5]) modelAc = ~modelAc;
      if (inst[4]) modelLink = ~modelLink;
      if (inst[0]) begin
        modelAc = modelAc + 1'b1;
        // Wrap to zero means a carry out of bit 0
        if (modelAc == '0) modelLink = ~modelLink;
      end
      lac = {modelLink, modelAc};
      case (inst[3:1])
        3'b100: lac = {lac[0], lac[12:1]};
        3'b101: lac = {lac[1:0], lac[12:2]};
        3'b010: lac = {lac[11:0], lac[12]};
        3'b011: lac = {lac[10:0], lac[12:11]};
        3'b001: lac = {lac[12], lac[5:0], lac[11:6]};
        default: ;
      endcase
      {modelLink, modelAc} = lac;
    end else if (!inst[0]) begin
      cond = (inst[6] && modelAc[11]) || (inst[5] && modelAc == '0) || (inst[4] && modelLink);
      // Reverse sense gives SPA, SNA, SZL
      if (inst[3]) cond = !cond;
      if (cond) modelPc = modelPc + 1'b1;
      if (inst[7]) modelAc = '0;
      modelHlt = inst[1];
    end else begin
      if (inst[7]) modelAc = '0;
      if (inst[4]) begin
        modelMq = modelAc;
        modelAc = inst[6] ? oldMq : '0;
      end else if (inst[6]) begin
        modelAc = modelAc | modelMq;
      end
    end
  endfunction

  // One whole instruction on the model
  function automatic void stepModel();
    word inst;
    word ea;
    word operand;
    logic [wordWidth:0] wide;
    inst = modelMem[modelPc];
    modelOp = inst[11:9];
    modelWrite = 1'b0;
    modelHlt = 1'b0;
    // Page zero, or the page holding the instruction
    ea = (inst & 12'o0177) | (inst[7] ? (modelPc & 12'o7600) : 12'o0000);
    // Pointers in 0010-0017 are not incremented
    if (inst[8] && inst[11:10] != 2'b11) ea = modelMem[ea];
    operand = modelMem[ea];
    modelPc = modelPc + 1'b1;
    wide = {1'b0, modelAc} + {1'b0, operand};
    case (inst[11:9])
      3'o0: modelAc = modelAc & operand;
      3'o1: begin
        modelAc = wide[wordWidth-1:0];
        modelLink = modelLink ^ wide[wordWidth];
      end
      3'o2: begin
        modelWrite = 1'b1;
        modelWrAddr = ea;
        modelWrData = operand + 1'b1;
        if (modelWrData == '0) modelPc = modelPc + 1'b1;
      end
      3'o3: begin
        modelWrite = 1'b1;
        modelWrAddr = ea;
        modelWrData = modelAc;
        modelAc = '0;
      end
      3'o4: begin
        modelWrite = 1'b1;
        modelWrAddr = ea;
        modelWrData = modelPc;
        modelPc = ea + 1'b1;
      end
      3'o5: modelPc = ea;
      3'o7: operateModel(inst);
      // IOT does nothing
      default: ;
    endcase
    if (modelWrite) modelMem[modelWrAddr] = modelWrData;
  endfunction

  // Compare on the falling edge, outputs settled by then
  always @(negedge clk) begin
    if (!reset) begin
      if (checkPending) begin
        checkValue("pc", pc, modelPc);
        checkValue("acc", acc, modelAc);
        checkValue("link", word'(link), word'(modelLink));
        checkValue("mq", mq, modelMq);
        checkValue("opcode", word'(opcodeOut), word'(modelOp));
        checkValue("halted", word'(halted), word'(expHalted));
        checkPending = 1'b0;
      end
      if (halt) haltSeen = 1'b1;
      if (instDone) begin
        stepModel();
        instCount++;
        expHalted = modelHlt || haltSeen;
        haltSeen = 1'b0;
        checkValue("memWrEn", word'(memWrEn), word'(modelWrite));
        if (modelWrite) begin
          checkValue("memAddr", memAddr, modelWrAddr);
          checkValue("memWrData", memWrData, modelWrData);
        end
        checkPending = 1'b1;
      end else begin
        checkValue("memWrEn", word'(memWrEn), 12'd0);
      end
    end
  end

  // Deposit the image, start at 0200 and wait for the machine to stop
  task automatic runImage(input string name, input int haltAfter);
    int i;
    int cycles;
    int startErrors;
    int startInst;
    startErrors = errorCount;
    startInst = instCount;
    haltSeen = 1'b0;
    for (i = 0; i < imgAddr.size(); i++) begin
      @(posedge clk);
      depositEn <= 1'b1;
      depositAddr <= imgAddr[i];
      depositData <= imgData[i];
      modelMem[imgAddr[i]] = imgData[i];
    end
    @(posedge clk);
    depositEn <= 1'b0;
    pcLoad <= 1'b1;
    depositAddr <= startAddr;
    @(posedge clk);
    pcLoad <= 1'b0;
    run <= 1'b1;
    modelPc = startAddr;
    @(posedge clk);
    run <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      // Optional one-cycle panel halt
      halt <= (cycles == haltAfter);
      // Run state is stable by the falling edge
      @(negedge clk);
    end while (!halted);
    @(posedge clk);
    halt <= 1'b0;
    imgAddr.delete();
    imgData.delete();
    testCount++;
    $display("Test %s: %0d instructions, %0d errors", name, instCount - startInst,
             errorCount - startErrors);
  endtask

  task automatic memRefProgram();
    // Auto-index location used as a plain pointer
    addWord(12'o0010, 12'o0030);
    addWord(12'o0020, randomWord());
    addWord(12'o0021, randomWord());
    addWord(12'o0022, 12'o0242);
    addWord(12'o0023, 12'o0216);
    addWord(12'o0030, randomWord());
    addWord(12'o0240, randomWord());
    addWord(12'o0241, randomWord());
    addWord(12'o0243, 12'o0021);
    nextAddr = startAddr;
    emit(12'o7300);
    emit(12'o1020);
    // Second add may carry into the link
    emit(12'o1021);
    emit(12'o3040);
    emit(12'o1240);
    emit(12'o0241);
    emit(12'o1410);
    emit(12'o3422);
    emit(12'o1242);
    emit(12'o1643);
    emit(12'o5423);
    emit(12'o7402);
    emit(12'o7402);
    emit(12'o7402);
    emit(12'o5217);
    emit(12'o7402);
  endtask

  task automatic iszJmsProgram();
    // Count of minus three
    addWord(12'o0250, 12'o7775);
    nextAddr = startAddr;
    emit(12'o7300);
    emit(12'o2250);
    emit(12'o5201);
    emit(12'o4260);
    emit(12'o7402);
    // Subroutine, return slot at 0260
    nextAddr = 12'o0260;
    emit(12'o0000);
    emit(12'o1250);
    emit(12'o7001);
    emit(12'o5660);
  endtask

  // Load AC from page zero, set the link at random, then one operate word
  task automatic group1Program();
    word i;
    nextAddr = startAddr;
    for (i = 0; i < 16; i++) begin
      addWord(12'o0020 + i, randomWord());
      emit(12'o7300);
      emit(12'o1020 + i);
      emit(($urandom % 2) ? 12'o7020 : 12'o7000);
      emit(12'o7000 | (randomWord() & 12'o0361) | word'(($urandom % 6) << 1));
    end
    emit(12'o7402);
  endtask

  task automatic group2Program();
    word i;
    nextAddr = startAddr;
    for (i = 0; i < 16; i++) begin
      addWord(12'o0020 + i, (i % 4 == 0) ? 12'o0000 : randomWord());
      emit(12'o7300);
      emit(12'o1020 + i);
      emit(($urandom % 2) ? 12'o7020 : 12'o7000);
      emit(12'o7400 | (randomWord() & 12'o0370));
      // Landing word for a skip
      emit(12'o7000);
    end
    emit(12'o7402);
  endtask

  task automatic group3Program();
    word i;
    nextAddr = startAddr;
    for (i = 0; i < 8; i++) begin
      addWord(12'o0020 + (i << 1), randomWord());
      addWord(12'o0021 + (i << 1), randomWord());
      emit(12'o7300);
      emit(12'o1020 + (i << 1));
      // MQL puts the first value in MQ
      emit(12'o7421);
      emit(12'o1021 + (i << 1));
      emit(12'o7401 | {4'b0, i[2], i[1], 1'b0, i[0], 4'b0});
    end
    emit(12'o7402);
  endtask

  initial begin
    void'($urandom(50056));
    reset = 1'b1;
    run = 1'b0;
    halt = 1'b0;
    depositEn = 1'b0;
    depositAddr = '0;
    depositData = '0;
    pcLoad = 1'b0;
    errorCount = 0;
    checkCount = 0;
    testCount = 0;
    instCount = 0;
    checkPending = 1'b0;
    haltSeen = 1'b0;
    expHalted = 1'b1;
    modelAc = '0;
    modelLink = 1'b0;
    modelMq = '0;
    modelPc = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkValue("halted", word'(halted), 12'd1);
    checkValue("instDone", word'(instDone), 12'd0);
    checkValue("memWrEn", word'(memWrEn), 12'd0);
    checkValue("pc", pc, 12'd0);
    checkValue("acc", acc, 12'd0);
    checkValue("link", word'(link), 12'd0);
    checkValue("mq", mq, 12'd0);
    testCount++;
    $display("Test reset: %0d errors", errorCount);
    memRefProgram();
    runImage("memory reference", 0);
    iszJmsProgram();
    runImage("isz jms", 0);
    group1Program();
    runImage("group 1", 0);
    group2Program();
    runImage("group 2", 0);
    // IAC loop that only a panel halt stops
    nextAddr = startAddr;
    emit(12'o7001);
    emit(12'o5200);
    runImage("halt pulse", int'(20 + $urandom % 12));
    group3Program();
    runImage("group 3", 0);
    errorCount = errorCount + dut.assertionChecks.failCount;
    $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdogCycles * clockPeriod);
    $display("Timeout: run did not finish within %0d cycles", watchdogCycles);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/pdp8Assertions.sv
`timescale 1ns/1ps
`default_nettype none

module pdp8Assertions (
  input wire SYSCLK,
  input wire reset,
  input wire halted,
  input wire instDone,
  input wire memWrEn
);

  // Failures seen so far
  int failCount = 0;

  // Core belongs to the front panel while halted
  noWriteWhileHalted: assert property (@(posedge SYSCLK) disable iff (reset)
    !(memWrEn && halted))
    else begin
      failCount++;
      $error("memWrEn high while halted");
    end

  // Completion is a single-cycle pulse
  singleInstDone: assert property (@(posedge SYSCLK) disable iff (reset)
    instDone |=> !instDone)
    else begin
      failCount++;
      $error("instDone high for two cycles");
    end

  haltedAfterReset: assert property (@(posedge SYSCLK) reset |=> halted)
    else begin
      failCount++;
      $error("halted low one cycle after reset");
    end

endmodule

`default_nettype wire

// File: verilog/pdp8Core.sv
`timescale 1ns/1ps
`default_nettype none

module pdp8Core
  import pdp8Pkg::*;
(
  input  wire            SYSCLK,
  input  wire            reset,
  input  wire            run,
  input  wire            halt,
  input  wire            depositEn,
  input  wire word       depositAddr,
  input  wire word       depositData,
  input  wire            pcLoad,
  output word            pc,
  output word            acc,
  output logic           link,
  output word            mq,
  output pdp8Pkg::opcode opcode,
  output logic           halted,
  output logic           instDone,
  output logic           memWrEn,
  output word            memAddr,
  output word            memWrData
);

  majorState state;
  word rdData;
  word effectiveAddr;
  word instWord;
  logic indirect;
  word acNext;
  logic linkNext;
  logic skip;
  logic haltReq;

  // Incrementers and adder
  word pcPlusOne;
  word eaPlusOne;
  word memInc;
  logic memIncZero;
  logic [wordWidth:0] tadSum;

  coreMemory memory (
    .SYSCLK     (SYSCLK),
    .cpuAddr    (memAddr),
    .cpuWrEn    (memWrEn),
    .cpuWrData  (memWrData),
    .depositEn  (depositEn && halted),
    .depositAddr(depositAddr),
    .depositData(depositData),
    .rdData     (rdData)
  );

  instRegister instReg (
    .SYSCLK       (SYSCLK),
    .reset        (reset),
    .state        (state),
    .pc           (pc),
    .rdData       (rdData),
    .opcode       (opcode),
    .indirect     (indirect),
    .effectiveAddr(effectiveAddr),
    .instWord     (instWord)
  );

  majorSequencer sequencer (
    .SYSCLK  (SYSCLK),
    .reset   (reset),
    .run     (run),
    .halt    (halt),
    .opcode  (opcode),
    .indirect(indirect),
    .haltReq (haltReq),
    .state   (state),
    .halted  (halted),
    .instDone(instDone)
  );

  operateUnit opUnit (
    .SYSCLK  (SYSCLK),
    .reset   (reset),
    .state   (state),
    .instWord(instWord),
    .acc     (acc),
    .link    (link),
    .acNext  (acNext),
    .linkNext(linkNext),
    .skip    (skip),
    .haltReq (haltReq),
    .mq      (mq)
  );

  assign pcPlusOne = pc + 1'b1;
  assign eaPlusOne = effectiveAddr + 1'b1;
  // Operand stays on rdData while the address is held
  assign memInc = rdData + 1'b1;
  assign memIncZero = (memInc == '0);
  assign tadSum = {1'b0, acc} + {1'b0, rdData};

  // PC during fetch, otherwise the effective address or pointer
  assign memAddr = (state == stFetch) ? pc : effectiveAddr;
  assign memWrEn = (state == stExecWrite);

  always_comb begin
    case (opcode)
      opDca:   memWrData = acc;
      // Return address, PC already past the JMS
      opJms:   memWrData = pc;
      default: memWrData = memInc;
    endcase
  end

  always_ff @(posedge SYSCLK) begin
    if (reset) begin
      pc <= '0;
    end else begin
      case (state)
        stHalted:   if (pcLoad) pc <= depositAddr;
        stFetch:    pc <= pcPlusOne;
        stExecRead: if (opcode == opJmp) pc <= effectiveAddr;
        // Group 2 skip
        stOperate:  if (skip) pc <= pcPlusOne;
        stExecWrite: begin
          if (opcode == opJms) begin
            pc <= eaPlusOne;
          end else if (opcode == opIsz && memIncZero) begin
            pc <= pcPlusOne;
          end
        end
        default: ;
      endcase
    end
  end

  // AC and link
  always_ff @(posedge SYSCLK) begin
    if (reset) begin
      acc <= '0;
      link <= 1'b0;
    end else if (state == stOperate) begin
      case (opcode)
        opAnd: acc <= acc & rdData;
        opTad: begin
          acc <= tadSum[wordWidth-1:0];
          link <= link ^ tadSum[wordWidth];
        end
        opOpr: begin
          acc <= acNext;
          link <= linkNext;
        end
        default: ;
      endcase
    end else if (state == stExecWrite && opcode == opDca) begin
      acc <= '0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/operateUnit.sv
`timescale 1ns/1ps
`default_nettype none

module operateUnit
  import pdp8Pkg::*;
(
  input  wire            SYSCLK,
  input  wire            reset,
  input  wire majorState state,
  input  wire word       instWord,
  input  wire word       acc,
  input  wire            link,
  output word            acNext,
  output logic           linkNext,
  output logic           skip,
  output logic           haltReq,
  output word            mq
);

  logic isOpr;
  logic group1;
  logic group2;
  logic group3;

  // Group 1 pipeline, one stage per event time
  word g1Ac1;
  word g1Ac2;
  logic g1Link1;
  logic g1Link2;
  logic [wordWidth:0] g1Sum;
  logic g1Link3;
  logic [wordWidth:0] g1Rot;

  // Group 2 skip test
  logic g2Cond;
  logic g2Skip;
  word g2Ac;

  // Group 3 MQ paths
  word g3Ac1;
  word g3Ac;

  assign isOpr = (opcode'(instWord[wordWidth-1 -: 3]) == opOpr);
  assign group1 = isOpr && !instWord[oprGroupBit];
  assign group2 = isOpr && instWord[oprGroupBit] && !instWord[group3Bit];
  assign group3 = isOpr && instWord[oprGroupBit] && instWord[group3Bit];

  // CLA and CLL
  assign g1Ac1 = instWord[7] ? '0 : acc;
  assign g1Link1 = instWord[6] ? 1'b0 : link;
  // CMA and CML
  assign g1Ac2 = instWord[5] ? ~g1Ac1 : g1Ac1;
  assign g1Link2 = instWord[4] ? ~g1Link1 : g1Link1;
  // IAC, carry out flips the link
  assign g1Sum = {1'b0, g1Ac2} + {{wordWidth{1'b0}}, instWord[0]};
  assign g1Link3 = g1Link2 ^ g1Sum[wordWidth];

  // Rotates work on the 13-bit link:AC
  always_comb begin
    case (instWord[3:1])
      3'b100:  g1Rot = {g1Sum[0], g1Link3, g1Sum[wordWidth-1:1]};
      3'b101:  g1Rot = {g1Sum[1:0], g1Link3, g1Sum[wordWidth-1:2]};
      3'b010:  g1Rot = {g1Sum[wordWidth-1:0], g1Link3};
      3'b011:  g1Rot = {g1Sum[wordWidth-2:0], g1Link3, g1Sum[wordWidth-1]};
      // BSW swaps the 6-bit halves
      3'b001:  g1Rot = {g1Link3, g1Sum[5:0], g1Sum[wordWidth-1:6]};
      default: g1Rot = {g1Link3, g1Sum[wordWidth-1:0]};
    endcase
  end

  // SMA, SZA, SNL ORed together
  assign g2Cond = (instWord[6] && acc[wordWidth-1])
               || (instWord[5] && (acc == '0))
               || (instWord[4] && link);
  // Bit 3 turns it into SPA, SNA, SZL ANDed
  assign g2Skip = instWord[3] ? !g2Cond : g2Cond;
  // CLA after the test, OSR contributes nothing
  assign g2Ac = instWord[7] ? '0 : acc;

  // CLA first, then MQA and MQL
  assign g3Ac1 = instWord[7] ? '0 : acc;
  always_comb begin
    if (instWord[4]) begin
      g3Ac = instWord[6] ? mq : '0;
    end else begin
      g3Ac = instWord[6] ? (g3Ac1 | mq) : g3Ac1;
    end
  end

  always_comb begin
    acNext = acc;
    linkNext = link;
    if (group1) begin
      acNext = g1Rot[wordWidth-1:0];
      linkNext = g1Rot[wordWidth];
    end else if (group2) begin
      acNext = g2Ac;
    end else if (group3) begin
      acNext = g3Ac;
    end
  end

  assign skip = group2 && g2Skip;
  assign haltReq = group2 && instWord[haltCode];

  // MQ takes the cleared-or-kept AC on MQL
  always_ff @(posedge SYSCLK) begin
    if (reset) begin
      mq <= '0;
    end else if (state == stOperate && group3 && instWord[4]) begin
      mq <= g3Ac1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/majorSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module majorSequencer
  import pdp8Pkg::*;
(
  input  wire                 SYSCLK,
  input  wire                 reset,
  input  wire                 run,
  input  wire                 halt,
  input  wire pdp8Pkg::opcode opcode,
  input  wire                 indirect,
  input  wire                 haltReq,
  output majorState           state,
  output logic                halted,
  output logic                instDone
);

  majorState nextState;
  majorState boundary;
  logic haltPending;
  logic lastState;

  // Final state of each instruction
  always_comb begin
    case (state)
      stExecRead:  lastState = (opcode == opJmp);
      // ISZ still has its write to do
      stOperate:   lastState = (opcode != opIsz);
      stExecWrite: lastState = 1'b1;
      default:     lastState = 1'b0;
    endcase
  end

  // Stop at the boundary on a panel halt or an HLT instruction
  assign boundary = (haltPending || halt || haltReq) ? stHalted : stFetch;

  always_comb begin
    nextState = state;
    case (state)
      stHalted:    if (run) nextState = stFetch;
      stFetch:     nextState = stDecode;
      stDecode: begin
        // IOT executes as a no-op through the operate state
        if (opcode == opOpr || opcode == opIot) begin
          nextState = stOperate;
        end else if (indirect) begin
          nextState = stDefer;
        end else begin
          nextState = stExecRead;
        end
      end
      stDefer:     nextState = stDeferWait;
      stDeferWait: nextState = stExecRead;
      stExecRead: begin
        if (lastState) begin
          nextState = boundary;
        end else if (opcode == opDca || opcode == opJms) begin
          nextState = stExecWrite;
        end else begin
          nextState = stExecWait;
        end
      end
      // Operand on the bus, ALU step follows
      stExecWait:  nextState = stOperate;
      stOperate:   nextState = lastState ? boundary : stExecWrite;
      stExecWrite: nextState = boundary;
      default:     nextState = stHalted;
    endcase
  end

  always_ff @(posedge SYSCLK) begin
    if (reset) begin
      state <= stHalted;
      haltPending <= 1'b0;
    end else begin
      state <= nextState;
      // Pending halt is consumed once stopped
      if (state == stHalted) begin
        haltPending <= 1'b0;
      end else if (halt) begin
        haltPending <= 1'b1;
      end
    end
  end

  assign halted = (state == stHalted);
  assign instDone = lastState;

endmodule

`default_nettype wire

// File: verilog/instRegister.sv
`timescale 1ns/1ps
`default_nettype none

module instRegister
  import pdp8Pkg::*;
(
  input  wire            SYSCLK,
  input  wire            reset,
  input  wire majorState state,
  input  wire word       pc,
  input  wire word       rdData,
  output pdp8Pkg::opcode opcode,
  output logic           indirect,
  output word            effectiveAddr,
  output word            instWord
);

  // Instruction register and the address it came from
  word ir;
  word instAddr;
  // Pointer word fetched during defer
  word pointer;
  logic deferred;
  // Page part of the direct address
  logic [addrWidth-pageOffsetWidth-1:0] page;
  word directAddr;

  always_ff @(posedge SYSCLK) begin
    if (reset) begin
      ir <= '0;
      instAddr <= '0;
      deferred <= 1'b0;
    end else begin
      // PC still points at the instruction during fetch
      if (state == stFetch) begin
        instAddr <= pc;
      end
      if (state == stDecode) begin
        ir <= rdData;
        deferred <= 1'b0;
      end
      // Pointer replaces the direct address from here on
      if (state == stDeferWait) begin
        deferred <= 1'b1;
      end
    end
  end

  always_ff @(posedge SYSCLK) begin
    if (state == stDeferWait) begin
      pointer <= rdData;
    end
  end

  // Page zero or the page the instruction sits in
  assign page = ir[pageBit] ? instAddr[addrWidth-1:pageOffsetWidth] : '0;
  assign directAddr = {page, ir[pageOffsetWidth-1:0]};
  // Locations 0010-0017 are plain pointers here
  assign effectiveAddr = deferred ? pointer : directAddr;

  // During decode the word is still on the memory bus, look ahead for dispatch
  assign opcode = pdp8Pkg::opcode'((state == stDecode) ? rdData[wordWidth-1 -: 3]
                                                       : ir[wordWidth-1 -: 3]);
  assign indirect = (state == stDecode) ? rdData[indirectBit] : ir[indirectBit];
  assign instWord = ir;

endmodule

`default_nettype wire

// File: verilog/coreMemory.sv
`timescale 1ns/1ps
`default_nettype none

module coreMemory
  import pdp8Pkg::*;
(
  input  wire      SYSCLK,
  input  wire word cpuAddr,
  input  wire      cpuWrEn,
  input  wire word cpuWrData,
  input  wire      depositEn,
  input  wire word depositAddr,
  input  wire word depositData,
  output word      rdData
);

  // Main store, no reset on contents
  word mem [memDepth];

  always_ff @(posedge SYSCLK) begin
    // Front panel deposit wins over the CPU port
    if (depositEn) begin
      mem[depositAddr] <= depositData;
    end else if (cpuWrEn) begin
      mem[cpuAddr] <= cpuWrData;
    end
    // Registered read, data valid one cycle after the address
    rdData <= mem[cpuAddr];
  end

endmodule

`default_nettype wire

// File: verilog/pdp8Pkg.sv
`default_nettype none

package pdp8Pkg;

  // Word and address sizes
  localparam int wordWidth = 12;
  localparam int addrWidth = 12;

  // Full 4K field of core
  localparam int memDepth = 2 ** addrWidth;

  // Memory-reference instruction fields
  localparam int pageOffsetWidth = 7;
  // I bit selects one level of indirection
  localparam int indirectBit = 8;
  // Z/C bit, clear means page zero
  localparam int pageBit = 7;

  // Operate instruction group selection
  localparam int oprGroupBit = 8;
  // Low bit set with bit 8 set means group 3 (MQ)
  localparam int group3Bit = 0;
  // HLT bit of group 2
  localparam int haltCode = 1;

  // One machine word, also used for addresses
  typedef logic [wordWidth-1:0] word;

  // Major opcode, IR bits 11..9
  typedef enum logic [2:0] {
    opAnd = 3'o0,
    opTad = 3'o1,
    opIsz = 3'o2,
    opDca = 3'o3,
    opJms = 3'o4,
    opJmp = 3'o5,
    opIot = 3'o6,
    opOpr = 3'o7
  } opcode;

  // Major states of the sequencer
  typedef enum logic [3:0] {
    stHalted    = 4'd0,
    stFetch     = 4'd1,
    stDecode    = 4'd2,
    stDefer     = 4'd3,
    stDeferWait = 4'd4,
    stExecRead  = 4'd5,
    stExecWait  = 4'd6,
    stExecWrite = 4'd7,
    stOperate   = 4'd8
  } majorState;

endpackage

`default_nettype wire
